// File: src/p2r_pkg.sv
// shared widths, vector types and FSM encodings; coefficients are assumed reduced below q
`default_nettype none

package p2r_pkg;

    // --------------------
    // field constants
    // --------------------
    localparam int unsigned DILITHIUM_Q     = 8380417;
    localparam int unsigned COEFF_W         = 24;
    localparam int unsigned COEFFS_PER_WORD = 4;
    localparam int unsigned T1_W            = 10;
    localparam int unsigned T0_W            = 13;
    localparam int unsigned SK_WORD_W       = 32;

    // --------------------
    // vector types
    // --------------------
    typedef logic [COEFF_W-1:0]                   coeff_t;
    // coefficient j sits at bits 24j upward
    typedef logic [COEFF_W*COEFFS_PER_WORD-1:0]   mem_word_t;
    // one group is two source words, eight lanes
    typedef logic [T1_W*2*COEFFS_PER_WORD-1:0]    t1_word_t;
    typedef logic [T0_W*2*COEFFS_PER_WORD-1:0]    t0_group_t;
    typedef logic [SK_WORD_W-1:0]                 sk_word_t;
    typedef logic [1:0]                           reg_addr_t;
    typedef logic [31:0]                          reg_data_t;

    // --------------------
    // FSM states
    // --------------------
    typedef enum logic [1:0] {
        T_RD_IDLE,
        T_RD_MEM,
        T_RD_DONE
    } rd_state_e;

    typedef enum logic [1:0] {
        SK_WR_IDLE,
        SK_WR_WAIT,
        SK_WR_MEM,
        SK_WR_DONE
    } sk_wr_state_e;

    typedef enum logic [1:0] {
        PK_WR_IDLE,
        PK_WR_API,
        PK_WR_DONE
    } pk_wr_state_e;

endpackage

`default_nettype wire

// File: src/p2r_regs.sv
// register block; start and zeroize are one-cycle pulses and must not be written together
`timescale 1ns/1ns
`default_nettype none

module p2r_regs #(
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        reg_wr,
    input  wire p2r_pkg::reg_addr_t    reg_addr,
    input  wire p2r_pkg::reg_data_t    reg_wdata,
    input  wire                        done,
    output p2r_pkg::reg_data_t         reg_rdata,
    output logic                       enable,
    output logic                       zeroize,
    output logic [MEM_ADDR_WIDTH-1:0]  src_base_addr,
    output logic [SK_ADDR_WIDTH-1:0]   sk_dest_base_addr
);
    import p2r_pkg::*;

    localparam reg_addr_t ADDR_CTRL   = 2'd0;
    localparam reg_addr_t ADDR_SRC    = 2'd1;
    localparam reg_addr_t ADDR_SK     = 2'd2;
    localparam reg_addr_t ADDR_STATUS = 2'd3;

    logic ctrl_wr;
    logic status_done;

    assign ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable            <= 1'b0;
            zeroize           <= 1'b0;
            src_base_addr     <= '0;
            sk_dest_base_addr <= '0;
            status_done       <= 1'b0;
        end else begin
            // control bits only live for the cycle after the write
            enable  <= ctrl_wr && reg_wdata[0];
            zeroize <= ctrl_wr && reg_wdata[1];
            if (zeroize) begin
                src_base_addr     <= '0;
                sk_dest_base_addr <= '0;
            end else if (reg_wr && (reg_addr == ADDR_SRC)) begin
                src_base_addr <= reg_wdata[MEM_ADDR_WIDTH-1:0];
            end else if (reg_wr && (reg_addr == ADDR_SK)) begin
                sk_dest_base_addr <= reg_wdata[SK_ADDR_WIDTH-1:0];
            end
            // sticky done, a new start or zeroize wins over a late done
            if (enable || zeroize) begin
                status_done <= 1'b0;
            end else if (done) begin
                status_done <= 1'b1;
            end
        end
    end

    // control register reads back 0
    always_comb begin
        case (reg_addr)
            ADDR_SRC:    reg_rdata = reg_data_t'(src_base_addr);
            ADDR_SK:     reg_rdata = reg_data_t'(sk_dest_base_addr);
            ADDR_STATUS: reg_rdata = reg_data_t'(status_done);
            default:     reg_rdata = '0;
        endcase
    end

    a_start_zeroize_apart: assert property (@(posedge clk) disable iff (!reset_n)
        !(enable && zeroize));

endmodule

`default_nettype wire

// File: src/p2r_ctrl.sv
// read, sk write and pk write sequencing; N must be a multiple of 64, pk addresses start at 0
`timescale 1ns/1ns
`default_nettype none

module p2r_ctrl #(
    parameter int DILITHIUM_K    = 8,
    parameter int DILITHIUM_N    = 256,
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14,
    parameter int PK_ADDR_WIDTH  = 8
) (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize,
    input  wire                        enable,
    input  wire [MEM_ADDR_WIDTH-1:0]   src_base_addr,
    input  wire [SK_ADDR_WIDTH-1:0]    sk_dest_base_addr,
    input  wire                        r_valid,
    input  wire                        sk_buff_valid,
    input  wire                        sk_buff_full,
    output logic                       rd_en,
    output logic [MEM_ADDR_WIDTH-1:0]  rd_addr_a,
    output logic                       sk_wren,
    output logic [SK_ADDR_WIDTH-1:0]   sk_addr_a,
    output logic                       pk_wren,
    output logic [PK_ADDR_WIDTH-1:0]   pk_addr,
    output logic                       sk_buff_enable,
    output logic                       done
);
    import p2r_pkg::*;

    // offsets of the last address each counter reaches
    localparam int RD_SPAN = DILITHIUM_K * DILITHIUM_N / COEFFS_PER_WORD - 2;
    localparam int SK_SPAN = DILITHIUM_K * DILITHIUM_N * T0_W / SK_WORD_W - 2;
    localparam int PK_LAST = DILITHIUM_K * DILITHIUM_N / (2 * COEFFS_PER_WORD) - 1;

    rd_state_e    rd_state, rd_state_nxt;
    sk_wr_state_e sk_state, sk_state_nxt;
    pk_wr_state_e pk_state, pk_state_nxt;

    logic [MEM_ADDR_WIDTH-1:0] rd_cnt;
    logic [MEM_ADDR_WIDTH-1:0] rd_prev;
    logic [MEM_ADDR_WIDTH-1:0] rd_last;
    logic [SK_ADDR_WIDTH-1:0]  sk_cnt;
    logic [SK_ADDR_WIDTH-1:0]  sk_last;
    logic [PK_ADDR_WIDTH-1:0]  pk_cnt;
    logic                      last_rd;
    logic                      last_sk;
    logic                      last_pk;
    logic                      accept;

    assign rd_last = src_base_addr + MEM_ADDR_WIDTH'(RD_SPAN);
    assign sk_last = sk_dest_base_addr + SK_ADDR_WIDTH'(SK_SPAN);
    assign last_rd = (rd_cnt == rd_last);
    assign last_sk = (sk_cnt == sk_last);
    assign last_pk = (pk_cnt == PK_ADDR_WIDTH'(PK_LAST));

    // --------------------
    // state and counters
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= T_RD_IDLE;
            sk_state <= SK_WR_IDLE;
            pk_state <= PK_WR_IDLE;
            rd_cnt   <= '0;
            rd_prev  <= '0;
            sk_cnt   <= '0;
            pk_cnt   <= '0;
        end else if (zeroize) begin
            rd_state <= T_RD_IDLE;
            sk_state <= SK_WR_IDLE;
            pk_state <= PK_WR_IDLE;
            rd_cnt   <= '0;
            rd_prev  <= '0;
            sk_cnt   <= '0;
            pk_cnt   <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            sk_state <= sk_state_nxt;
            pk_state <= pk_state_nxt;
            rd_prev  <= rd_addr_a;
            if (rd_state == T_RD_IDLE) begin
                rd_cnt <= src_base_addr;
            end else if ((rd_state == T_RD_MEM) && !sk_buff_full && !last_rd) begin
                rd_cnt <= rd_cnt + MEM_ADDR_WIDTH'(2);
            end
            if (sk_state == SK_WR_IDLE) begin
                sk_cnt <= sk_dest_base_addr;
            end else if (sk_wren && !last_sk) begin
                sk_cnt <= sk_cnt + SK_ADDR_WIDTH'(2);
            end
            if (pk_state == PK_WR_IDLE) begin
                pk_cnt <= '0;
            end else if (pk_wren && !last_pk) begin
                pk_cnt <= pk_cnt + PK_ADDR_WIDTH'(1);
            end
        end
    end

    // --------------------
    // next-state logic
    // --------------------
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            T_RD_IDLE: rd_state_nxt = enable ? T_RD_MEM : T_RD_IDLE;
            T_RD_MEM:  rd_state_nxt = (last_rd && !sk_buff_full) ? T_RD_DONE : T_RD_MEM;
            // hold until the last group has been taken
            T_RD_DONE: rd_state_nxt = sk_buff_full ? T_RD_DONE : T_RD_IDLE;
            default:   rd_state_nxt = T_RD_IDLE;
        endcase
    end

    always_comb begin
        sk_state_nxt = sk_state;
        case (sk_state)
            SK_WR_IDLE: sk_state_nxt = (rd_state != T_RD_IDLE) ? SK_WR_WAIT : SK_WR_IDLE;
            SK_WR_WAIT: sk_state_nxt = SK_WR_MEM;
            SK_WR_MEM:  sk_state_nxt = (sk_wren && last_sk) ? SK_WR_DONE : SK_WR_MEM;
            default:    sk_state_nxt = SK_WR_IDLE;
        endcase
    end

    always_comb begin
        pk_state_nxt = pk_state;
        case (pk_state)
            PK_WR_IDLE: pk_state_nxt = (rd_state != T_RD_IDLE) ? PK_WR_API : PK_WR_IDLE;
            PK_WR_API:  pk_state_nxt = (pk_wren && last_pk) ? PK_WR_DONE : PK_WR_API;
            default:    pk_state_nxt = PK_WR_IDLE;
        endcase
    end

    // --------------------
    // outputs
    // --------------------
    assign accept = r_valid && !sk_buff_full;
    assign rd_en  = (rd_state != T_RD_IDLE);
    // a stall repeats the last address so the rejected data comes back next cycle
    assign rd_addr_a = sk_buff_full ? rd_prev : rd_cnt;

    assign pk_wren        = (pk_state == PK_WR_API) && accept;
    assign sk_buff_enable = pk_wren;
    assign pk_addr        = pk_cnt;

    assign sk_wren   = (sk_state == SK_WR_MEM) && sk_buff_valid;
    assign sk_addr_a = sk_cnt;
    assign done      = (sk_state == SK_WR_DONE);

    a_sk_addr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        sk_wren |-> (SK_ADDR_WIDTH'(sk_cnt - sk_dest_base_addr) <= SK_SPAN));

endmodule

`default_nettype wire

// File: src/p2r_core.sv
// eight-lane power2round split; t1/t0 are combinational from read data, inputs must be below q
`timescale 1ns/1ns
`default_nettype none

module p2r_core (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         zeroize,
    input  wire                         rd_en,
    input  wire p2r_pkg::mem_word_t     rd_data_a,
    input  wire p2r_pkg::mem_word_t     rd_data_b,
    output logic                        r_valid,
    output p2r_pkg::t1_word_t           t1_word,
    output p2r_pkg::t0_group_t          t0_group
);
    import p2r_pkg::*;

    localparam int LANES = 2 * COEFFS_PER_WORD;
    localparam int HALF  = 2 ** (T0_W - 1);

    coeff_t coeff [LANES];

    // lanes 0-3 from port a, 4-7 from port b
    always_comb begin
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            coeff[i]                   = rd_data_a[i*COEFF_W +: COEFF_W];
            coeff[i + COEFFS_PER_WORD] = rd_data_b[i*COEFF_W +: COEFF_W];
        end
    end

    always_comb begin
        coeff_t          rounded;
        coeff_t          diff;
        logic [T1_W-1:0] t1;
        for (int i = 0; i < LANES; i++) begin
            rounded = coeff[i] + COEFF_W'(HALF - 1);
            t1      = rounded[T0_W +: T1_W];
            // stored t0 is 4096 - (r - t1*8192), always in 0..8191
            diff    = COEFF_W'({t1, {T0_W{1'b0}}}) + COEFF_W'(HALF) - coeff[i];
            t1_word[i*T1_W +: T1_W]  = t1;
            t0_group[i*T0_W +: T0_W] = diff[T0_W-1:0];
        end
    end

    // memory data shows up one cycle after the read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
        end else if (zeroize) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= rd_en;
        end
    end

    for (genvar g = 0; g < LANES; g++) begin : g_range
        a_coeff_below_q: assert property (@(posedge clk) disable iff (!reset_n)
            r_valid |-> (coeff[g] < DILITHIUM_Q));
    end

endmodule

`default_nettype wire

// File: src/t0_pack_buffer.sv
// 256-bit t0 packing buffer; the caller must not append while full nor write below 64 bits
`timescale 1ns/1ns
`default_nettype none

module t0_pack_buffer (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               zeroize,
    input  wire                               sk_buff_enable,
    input  wire p2r_pkg::t0_group_t           t0_group,
    input  wire                               sk_wren,
    output logic                              sk_buff_valid,
    output logic                              sk_buff_full,
    output logic [2*p2r_pkg::SK_WORD_W-1:0]   sk_chunk
);
    import p2r_pkg::*;

    localparam int DEPTH      = 256;
    localparam int CHUNK_W    = 2 * SK_WORD_W;
    localparam int GROUP_W    = $bits(t0_group_t);
    localparam int FULL_LEVEL = DEPTH - GROUP_W;
    localparam int LVL_W      = $clog2(DEPTH + 1);

    logic [DEPTH-1:0] store;
    logic [DEPTH-1:0] store_kept;
    logic [DEPTH-1:0] store_nxt;
    logic [LVL_W-1:0] level;
    logic [LVL_W-1:0] level_kept;
    logic [LVL_W-1:0] level_nxt;

    // drop the written chunk first, then append above what is left
    always_comb begin
        store_kept = sk_wren ? (store >> CHUNK_W) : store;
        level_kept = sk_wren ? (level - LVL_W'(CHUNK_W)) : level;
        // bits above the fill level are stale
        store_kept = store_kept & ~({DEPTH{1'b1}} << level_kept);
        store_nxt  = store_kept;
        level_nxt  = level_kept;
        if (sk_buff_enable) begin
            store_nxt = store_kept | (DEPTH'(t0_group) << level_kept);
            level_nxt = level_kept + LVL_W'(GROUP_W);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            level        <= '0;
            sk_buff_full <= 1'b0;
        end else if (zeroize) begin
            level        <= '0;
            sk_buff_full <= 1'b0;
        end else begin
            level        <= level_nxt;
            sk_buff_full <= (level_nxt > LVL_W'(FULL_LEVEL));
        end
    end

    always_ff @(posedge clk) begin
        store <= store_nxt;
    end

    assign sk_buff_valid = (level >= LVL_W'(CHUNK_W));
    assign sk_chunk      = store[CHUNK_W-1:0];

    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        sk_buff_enable |-> (int'(level_kept) + GROUP_W <= DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        sk_wren |-> sk_buff_valid);

endmodule

`default_nettype wire

// File: src/p2r_top.sv
// power2round top; source reads hit addr and addr+1, sk writes hit addr and addr+1
`timescale 1ns/1ns
`default_nettype none

module p2r_top #(
    parameter int DILITHIUM_K    = 8,
    parameter int DILITHIUM_N    = 256,
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14,
    parameter int PK_ADDR_WIDTH  = 8
) (
    input  wire                        clk,
    input  wire                        reset_n,
    // register port
    input  wire                        reg_wr,
    input  wire p2r_pkg::reg_addr_t    reg_addr,
    input  wire p2r_pkg::reg_data_t    reg_wdata,
    output p2r_pkg::reg_data_t         reg_rdata,
    // source memory
    output logic                       rd_en_a,
    output logic                       rd_en_b,
    output logic [MEM_ADDR_WIDTH-1:0]  rd_addr_a,
    output logic [MEM_ADDR_WIDTH-1:0]  rd_addr_b,
    input  wire p2r_pkg::mem_word_t    rd_data_a,
    input  wire p2r_pkg::mem_word_t    rd_data_b,
    // secret-key memory
    output logic                       sk_wren,
    output logic [SK_ADDR_WIDTH-1:0]   sk_addr_a,
    output logic [SK_ADDR_WIDTH-1:0]   sk_addr_b,
    output p2r_pkg::sk_word_t          sk_data_a,
    output p2r_pkg::sk_word_t          sk_data_b,
    // public-key port
    output logic                       pk_wren,
    output logic [PK_ADDR_WIDTH-1:0]   pk_addr,
    output p2r_pkg::t1_word_t          pk_data
);
    import p2r_pkg::*;

    logic                      enable;
    logic                      zeroize;
    logic                      done;
    logic [MEM_ADDR_WIDTH-1:0] src_base_addr;
    logic [SK_ADDR_WIDTH-1:0]  sk_dest_base_addr;
    logic                      rd_en;
    logic                      r_valid;
    logic                      sk_buff_valid;
    logic                      sk_buff_full;
    logic                      sk_buff_enable;
    t0_group_t                 t0_group;
    logic [2*SK_WORD_W-1:0]    sk_chunk;

    p2r_regs #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH)
    ) u_regs (
        .clk, .reset_n, .reg_wr, .reg_addr, .reg_wdata, .done,
        .reg_rdata, .enable, .zeroize, .src_base_addr, .sk_dest_base_addr
    );

    p2r_ctrl #(
        .DILITHIUM_K    (DILITHIUM_K),
        .DILITHIUM_N    (DILITHIUM_N),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH),
        .PK_ADDR_WIDTH  (PK_ADDR_WIDTH)
    ) u_ctrl (
        .clk, .reset_n, .zeroize, .enable, .src_base_addr, .sk_dest_base_addr,
        .r_valid, .sk_buff_valid, .sk_buff_full,
        .rd_en, .rd_addr_a, .sk_wren, .sk_addr_a, .pk_wren, .pk_addr,
        .sk_buff_enable, .done
    );

    p2r_core u_core (
        .clk, .reset_n, .zeroize, .rd_en, .rd_data_a, .rd_data_b,
        .r_valid, .t1_word (pk_data), .t0_group
    );

    t0_pack_buffer u_buffer (
        .clk, .reset_n, .zeroize, .sk_buff_enable, .t0_group, .sk_wren,
        .sk_buff_valid, .sk_buff_full, .sk_chunk
    );

    // port b always serves the next word
    assign rd_en_a   = rd_en;
    assign rd_en_b   = rd_en;
    assign rd_addr_b = rd_addr_a + MEM_ADDR_WIDTH'(1);
    assign sk_addr_b = sk_addr_a + SK_ADDR_WIDTH'(1);
    assign sk_data_a = sk_chunk[SK_WORD_W-1:0];
    assign sk_data_b = sk_chunk[2*SK_WORD_W-1:SK_WORD_W];

endmodule

`default_nettype wire

// File: bench/p2r_mem_model.sv
// behavioral memories for the testbench; source reads take one cycle, writes are counted per address
`timescale 1ns/1ns
`default_nettype none

module p2r_mem_model #(
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14,
    parameter int PK_ADDR_WIDTH  = 8
) (
    input  wire                        clk,
    input  wire                        clear,
    input  wire                        load_en,
    input  wire [MEM_ADDR_WIDTH-1:0]   load_addr,
    input  wire p2r_pkg::mem_word_t    load_data,
    input  wire                        rd_en_a,
    input  wire                        rd_en_b,
    input  wire [MEM_ADDR_WIDTH-1:0]   rd_addr_a,
    input  wire [MEM_ADDR_WIDTH-1:0]   rd_addr_b,
    output p2r_pkg::mem_word_t         rd_data_a,
    output p2r_pkg::mem_word_t         rd_data_b,
    input  wire                        sk_wren,
    input  wire [SK_ADDR_WIDTH-1:0]    sk_addr_a,
    input  wire [SK_ADDR_WIDTH-1:0]    sk_addr_b,
    input  wire p2r_pkg::sk_word_t     sk_data_a,
    input  wire p2r_pkg::sk_word_t     sk_data_b,
    input  wire                        pk_wren,
    input  wire [PK_ADDR_WIDTH-1:0]    pk_addr,
    input  wire p2r_pkg::t1_word_t     pk_data
);
    import p2r_pkg::*;

    mem_word_t src_mem  [2**MEM_ADDR_WIDTH];
    sk_word_t  sk_mem   [2**SK_ADDR_WIDTH];
    int        sk_count [2**SK_ADDR_WIDTH];
    t1_word_t  pk_mem   [2**PK_ADDR_WIDTH];
    int        pk_count [2**PK_ADDR_WIDTH];
    int        pk_total = 0;
    mem_word_t data_a_q = '0;
    mem_word_t data_b_q = '0;

    assign rd_data_a = data_a_q;
    assign rd_data_b = data_b_q;

    // source memory, loaded by the testbench between runs
    always @(posedge clk) begin
        if (load_en) begin
            src_mem[load_addr] <= load_data;
        end
        if (rd_en_a) begin
            data_a_q <= src_mem[rd_addr_a];
        end
        if (rd_en_b) begin
            data_b_q <= src_mem[rd_addr_b];
        end
    end

    // sk and pk capture, clear wipes the counts
    always @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < 2**SK_ADDR_WIDTH; i++) begin
                sk_count[i] <= 0;
            end
            for (int i = 0; i < 2**PK_ADDR_WIDTH; i++) begin
                pk_count[i] <= 0;
            end
            pk_total <= 0;
        end else begin
            if (sk_wren) begin
                sk_mem[sk_addr_a]   <= sk_data_a;
                sk_mem[sk_addr_b]   <= sk_data_b;
                sk_count[sk_addr_a] <= sk_count[sk_addr_a] + 1;
                sk_count[sk_addr_b] <= sk_count[sk_addr_b] + 1;
            end
            if (pk_wren) begin
                pk_mem[pk_addr]   <= pk_data;
                pk_count[pk_addr] <= pk_count[pk_addr] + 1;
                pk_total          <= pk_total + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_p2r.sv
// testbench for p2r_top at default K and N; memories are behavioral, stimulus comes from a seeded LFSR
`timescale 1ns/1ns
`default_nettype none

module tb_p2r;
    import p2r_pkg::*;

    localparam int DILITHIUM_K    = 8;
    localparam int DILITHIUM_N    = 256;
    localparam int MEM_ADDR_WIDTH = 15;
    localparam int SK_ADDR_WIDTH  = 14;
    localparam int PK_ADDR_WIDTH  = 8;
    localparam int GROUPS         = DILITHIUM_K * DILITHIUM_N / 8;
    localparam int SRC_WORDS      = DILITHIUM_K * DILITHIUM_N / COEFFS_PER_WORD;
    localparam int SK_WORDS       = DILITHIUM_K * DILITHIUM_N * T0_W / SK_WORD_W;
    // four runs at three cycles per group with a fourfold margin
    localparam int TIMEOUT_CYCLES = 4 * 3 * GROUPS * 4;
    localparam logic [31:0] SEED  = 32'h59966326;
    localparam reg_addr_t REG_CTRL   = 2'd0;
    localparam reg_addr_t REG_SRC    = 2'd1;
    localparam reg_addr_t REG_SK     = 2'd2;
    localparam reg_addr_t REG_STATUS = 2'd3;

    logic                      clk;
    logic                      reset_n;
    logic                      reg_wr;
    reg_addr_t                 reg_addr;
    reg_data_t                 reg_wdata;
    reg_data_t                 reg_rdata;
    logic                      rd_en_a;
    logic                      rd_en_b;
    logic [MEM_ADDR_WIDTH-1:0] rd_addr_a;
    logic [MEM_ADDR_WIDTH-1:0] rd_addr_b;
    mem_word_t                 rd_data_a;
    mem_word_t                 rd_data_b;
    logic                      sk_wren;
    logic [SK_ADDR_WIDTH-1:0]  sk_addr_a;
    logic [SK_ADDR_WIDTH-1:0]  sk_addr_b;
    sk_word_t                  sk_data_a;
    sk_word_t                  sk_data_b;
    logic                      pk_wren;
    logic [PK_ADDR_WIDTH-1:0]  pk_addr;
    t1_word_t                  pk_data;
    logic                      clear;
    logic                      load_en;
    logic [MEM_ADDR_WIDTH-1:0] load_addr;
    mem_word_t                 load_data;

    logic [31:0] lfsr;
    int          cycle_count = 0;
    int unsigned ref_coeff [DILITHIUM_K * DILITHIUM_N];

    p2r_top #(
        .DILITHIUM_K    (DILITHIUM_K),
        .DILITHIUM_N    (DILITHIUM_N),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH),
        .PK_ADDR_WIDTH  (PK_ADDR_WIDTH)
    ) uut (.*);

    p2r_mem_model #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH),
        .PK_ADDR_WIDTH  (PK_ADDR_WIDTH)
    ) mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: the run hung, no result after %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    // --------------------
    // failure reporting
    // --------------------
    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic check_t1_word(input t1_word_t got, input t1_word_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_sk_word(input sk_word_t got, input sk_word_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_coeff(output coeff_t c);
        logic [31:0] v;
        draw_bits(23, v);
        while (v >= DILITHIUM_Q) begin
            draw_bits(23, v);
        end
        c = coeff_t'(v);
    endtask

    // bases of 14 and 13 bits keep a whole run inside both memories
    task automatic pick_bases(output logic [MEM_ADDR_WIDTH-1:0] src_base,
                              output logic [SK_ADDR_WIDTH-1:0] sk_base);
        logic [31:0] v;
        draw_bits(14, v);
        while (v == 0) begin
            draw_bits(14, v);
        end
        src_base = MEM_ADDR_WIDTH'(v);
        draw_bits(13, v);
        while (v == 0) begin
            draw_bits(13, v);
        end
        sk_base = SK_ADDR_WIDTH'(v);
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        tick();
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_addr = addr;
        tick();
        data = reg_rdata;
    endtask

    task automatic load_source(input logic [MEM_ADDR_WIDTH-1:0] base);
        mem_word_t word;
        coeff_t    c;
        for (int w = 0; w < SRC_WORDS; w++) begin
            for (int j = 0; j < COEFFS_PER_WORD; j++) begin
                draw_coeff(c);
                ref_coeff[w * COEFFS_PER_WORD + j] = c;
                word[j*COEFF_W +: COEFF_W] = c;
            end
            load_en   = 1'b1;
            load_addr = base + MEM_ADDR_WIDTH'(w);
            load_data = word;
            tick();
        end
        load_en = 1'b0;
    endtask

    task automatic watch_idle(input int count);
        for (int n = 0; n < count; n++) begin
            if (pk_wren || sk_wren || rd_en_a || rd_en_b) begin
                report_error("a memory enable was active while the block should be idle");
            end
            tick();
        end
    endtask

    task automatic start_run(input logic [MEM_ADDR_WIDTH-1:0] src_base,
                             input logic [SK_ADDR_WIDTH-1:0] sk_base);
        reg_data_t value;
        clear = 1'b1;
        tick();
        clear = 1'b0;
        load_source(src_base);
        write_reg(REG_SRC, reg_data_t'(src_base));
        write_reg(REG_SK, reg_data_t'(sk_base));
        read_reg(REG_SK, value);
        check_reg(value, reg_data_t'(sk_base), "secret-key base readback");
        write_reg(REG_CTRL, 32'h1);
        // start clears the sticky done one cycle later
        read_reg(REG_STATUS, value);
        check_reg(value, '0, "status after start");
    endtask

    task automatic wait_for_done();
        reg_data_t value;
        read_reg(REG_STATUS, value);
        while (value[0] !== 1'b1) begin
            read_reg(REG_STATUS, value);
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic t1_word_t expected_t1(input int g);
        t1_word_t    word;
        int unsigned r;
        for (int i = 0; i < 8; i++) begin
            r = ref_coeff[8 * g + i];
            // nearest multiple of 8192 with ties rounding down
            word[i*T1_W +: T1_W] = T1_W'((r + 4095) >> 13);
        end
        return word;
    endfunction

    function automatic logic [T0_W-1:0] t0_field(input int unsigned r);
        int t1;
        int t0;
        t1 = int'((r + 4095) >> 13);
        t0 = int'(r) - t1 * 8192;
        return T0_W'(4096 - t0);
    endfunction

    // t0 values are packed lsb first at 13 bits per coefficient
    function automatic sk_word_t expected_sk_word(input int w);
        sk_word_t        word;
        logic [T0_W-1:0] field;
        int              pos;
        for (int b = 0; b < SK_WORD_W; b++) begin
            pos     = w * SK_WORD_W + b;
            field   = t0_field(ref_coeff[pos / T0_W]);
            word[b] = field[pos % T0_W];
        end
        return word;
    endfunction

    task automatic verify_results(input logic [SK_ADDR_WIDTH-1:0] sk_base);
        logic [SK_ADDR_WIDTH-1:0] offset;
        int                       count;
        if (mem_model.pk_total != GROUPS) begin
            report_error($sformatf("%0d public-key writes instead of %0d",
                                   mem_model.pk_total, GROUPS));
        end
        for (int g = 0; g < GROUPS; g++) begin
            if (mem_model.pk_count[g] != 1) begin
                report_error($sformatf("public-key address %0d written %0d times",
                                       g, mem_model.pk_count[g]));
            end
            check_t1_word(mem_model.pk_mem[g], expected_t1(g),
                          $sformatf("public-key word %0d", g));
        end
        for (int a = 0; a < 2**SK_ADDR_WIDTH; a++) begin
            offset = SK_ADDR_WIDTH'(a) - sk_base;
            count  = mem_model.sk_count[a];
            if (int'(offset) < SK_WORDS) begin
                if (count != 1) begin
                    report_error($sformatf("secret-key address %0d written %0d times", a, count));
                end
                check_sk_word(mem_model.sk_mem[a], expected_sk_word(int'(offset)),
                              $sformatf("secret-key word %0d", offset));
            end else if (count != 0) begin
                report_error($sformatf("secret-key address %0d outside the key was written", a));
            end
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        reg_data_t                 value;
        logic [MEM_ADDR_WIDTH-1:0] src_base;
        logic [SK_ADDR_WIDTH-1:0]  sk_base;
        reset_n   = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = REG_CTRL;
        reg_wdata = '0;
        clear     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = SEED;
        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // quiet after reset
        read_reg(REG_STATUS, value);
        check_reg(value, '0, "status after reset");
        watch_idle(20);

        // first run from base 0
        start_run('0, '0);
        wait_for_done();
        verify_results('0);

        // random bases and fresh data
        pick_bases(src_base, sk_base);
        start_run(src_base, sk_base);
        wait_for_done();
        verify_results(sk_base);

        // zeroize also drops the done of a finished run
        write_reg(REG_CTRL, 32'h2);
        read_reg(REG_STATUS, value);
        check_reg(value, '0, "status after zeroize");

        // zeroize half way through a run
        pick_bases(src_base, sk_base);
        start_run(src_base, sk_base);
        while (mem_model.pk_total < GROUPS / 2) begin
            tick();
        end
        write_reg(REG_CTRL, 32'h2);
        tick();
        watch_idle(20);
        read_reg(REG_SRC, value);
        check_reg(value, '0, "source base after zeroize");

        // full run after the zeroize
        pick_bases(src_base, sk_base);
        start_run(src_base, sk_base);
        wait_for_done();
        verify_results(sk_base);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/p2r_pkg.sv
src/p2r_regs.sv
src/p2r_ctrl.sv
src/p2r_core.sv
src/t0_pack_buffer.sv
src/p2r_top.sv
bench/p2r_mem_model.sv
bench/tb_p2r.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_p2r -f files.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_p2r > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the log decides the outcome
if grep -qx "Test passed" "$LOG"; then
    echo "run passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
